//--- tb.f
+incdir+sim
logic/vec_pkg.sv
logic/vec_fifo.sv
logic/vrf.sv
logic/uop_decode.sv
logic/vec_alu.sv
logic/retire_unit.sv
logic/vec_backend.sv
sim/tb_top.sv

//--- sim/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// One table row: idle cycles, then the instruction
typedef struct packed {
  int        idle;
  vec_inst_t inst;
} case_entry_t;

case_entry_t case_tbl[$];
string       case_name[$];

task automatic add_case(input string name, input int idle, input vec_op_e op, input int vd,
                        input int vs1, input int vs2, input int vl, input xrf_data_t rs1);
  case_entry_t e;
  e.idle     = idle;
  e.inst.op  = op;
  e.inst.vd  = vreg_idx_t'(vd);
  e.inst.vs1 = vreg_idx_t'(vs1);
  e.inst.vs2 = vreg_idx_t'(vs2);
  e.inst.vl  = 3'(vl);
  e.inst.rs1 = rs1;
  case_tbl.push_back(e);
  case_name.push_back(name);
endtask

task automatic load_cases();
  // name, idle, op, vd, vs1, vs2, vl, rs1
  add_case("init_v1",   2, op_vmv_vx, 1,  0, 0,  4, 32'h0000_1234);
  add_case("init_v2",   0, op_vmv_vx, 2,  0, 0,  4, 32'h0000_7000);
  add_case("init_v3",   0, op_vmv_vx, 3,  0, 0,  4, 32'hffff_f000);
  add_case("init_v4",   0, op_vmv_vx, 4,  0, 0,  4, 32'h0000_8001);
  add_case("add_v5",    3, op_vadd,   5,  2, 1,  4, 32'h0);
  add_case("sub_v6",    0, op_vsub,   6,  2, 1,  4, 32'h0);
  add_case("add_wrap",  0, op_vadd,   7,  2, 2,  4, 32'h0);
  add_case("sadd_pos",  2, op_vsadd,  8,  2, 2,  4, 32'h0);
  add_case("sadd_neg",  0, op_vsadd,  9,  3, 4,  4, 32'h0);
  add_case("sadd_ok",   0, op_vsadd,  10, 1, 1,  4, 32'h0);
  add_case("sadd_vl0",  0, op_vsadd,  11, 2, 2,  0, 32'h0);
  add_case("init_v12a", 2, op_vmv_vx, 12, 0, 0,  4, 32'h0000_7fff);
  add_case("init_v12b", 0, op_vmv_vx, 12, 0, 0,  2, 32'h0000_0005);
  add_case("sadd_part", 0, op_vsadd,  13, 1, 12, 4, 32'h0);
  add_case("sadd_tail", 0, op_vsadd,  14, 1, 12, 2, 32'h0);
  add_case("add_tail",  2, op_vadd,   5,  3, 1,  2, 32'h0);
  add_case("sub_self",  0, op_vsub,   6,  2, 6,  3, 32'h0);
  add_case("add_vl0",   0, op_vadd,   5,  1, 1,  0, 32'h0);
  add_case("chain_1",   3, op_vadd,   15, 1, 1,  4, 32'h0);
  add_case("chain_2",   0, op_vadd,   15, 1, 15, 4, 32'h0);
  add_case("chain_3",   0, op_vsub,   16, 1, 15, 4, 32'h0);
  add_case("chain_4",   0, op_vadd,   17, 15, 16, 4, 32'h0);
  add_case("mv_neg",    2, op_vmv_vx, 18, 0, 0,  4, 32'hffff_8abc);
  add_case("xs_neg",    0, op_vmv_xs, 0,  0, 18, 4, 32'h0);
  add_case("xs_pos",    0, op_vmv_xs, 0,  0, 1,  4, 32'h0);
  add_case("b_xs_v2",   0, op_vmv_xs, 0,  0, 2,  4, 32'h0);
  add_case("b_add",     0, op_vadd,   19, 2, 1,  4, 32'h0);
  add_case("b_xs_v19",  0, op_vmv_xs, 0,  0, 19, 4, 32'h0);
  add_case("b_xs_v3",   0, op_vmv_xs, 0,  0, 3,  4, 32'h0);
  add_case("b_sadd",    0, op_vsadd,  20, 1, 2,  4, 32'h0);
  add_case("b_xs_v20",  0, op_vmv_xs, 0,  0, 20, 4, 32'h0);
  add_case("b_xs_v4",   0, op_vmv_xs, 0,  0, 4,  4, 32'h0);
  add_case("b_xs_v13",  0, op_vmv_xs, 0,  0, 13, 4, 32'h0);
  add_case("b_add_vl1", 0, op_vadd,   21, 1, 3,  1, 32'h0);
endtask

`endif

//--- sim/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import vec_pkg::*;

  localparam int max_cases = 64;
  localparam int lane_max  = 2**(sew-1) - 1;
  localparam int lane_min  = -(2**(sew-1));

  logic      clk = 1'b0;
  logic      rst_n;
  logic      inst_valid;
  vec_inst_t inst;
  logic      inst_ready;
  logic      xrf_valid;
  xrf_data_t xrf_data;
  logic      xrf_ready;
  logic      rt_valid;
  vreg_idx_t rt_index;
  vdata_t    rt_data;
  vstrb_t    rt_strobe;
  logic      vxsat_set;

  integer    seed = 52329;
  int        n_checks;
  int        n_errors;
  int        n_writes;
  int        rt_count;
  int        cycles;
  int        cycle_limit = 1000000;

  // Expected results per table row
  vdata_t    exp_data [max_cases];
  vstrb_t    exp_strb [max_cases];
  logic      exp_sat  [max_cases];
  xrf_data_t exp_xrf  [max_cases];
  int        rt_q[$];   // Row numbers in retire order
  int        xrf_q[$];

  `include "tb_cases.svh"

  vec_backend u_dut (
    .clk(clk), .rst_n(rst_n),
    .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
    .xrf_valid(xrf_valid), .xrf_data(xrf_data), .xrf_ready(xrf_ready),
    .rt_valid(rt_valid), .rt_index(rt_index), .rt_data(rt_data),
    .rt_strobe(rt_strobe), .vxsat_set(vxsat_set)
  );

  always #5 clk = ~clk;

  // Sequential model of the vector unit over the whole table
  task automatic predict();
    vdata_t    regs [num_vregs];
    vec_inst_t c;
    vdata_t    new_v;
    int        a_l;
    int        b_l;
    int        r_l;
    for (int r = 0; r < num_vregs; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < case_tbl.size(); i++) begin
      c           = case_tbl[i].inst;
      new_v       = regs[c.vd];
      exp_strb[i] = '0;
      exp_sat[i]  = 1'b0;
      for (int l = 0; l < num_lanes; l++) begin
        a_l = $signed(regs[c.vs2][l*sew +: sew]);
        b_l = $signed(regs[c.vs1][l*sew +: sew]);
        case (c.op)
          op_vsub: r_l = a_l - b_l;
          op_vadd, op_vsadd: r_l = a_l + b_l;
          default: r_l = c.rs1;
        endcase
        if (l < c.vl) begin
          if (c.op == op_vsadd && (r_l > lane_max || r_l < lane_min)) begin
            exp_sat[i] = 1'b1;
            r_l = (r_l > 0) ? lane_max : lane_min;
          end
          new_v[l*sew +: sew] = r_l[sew-1:0];
          exp_strb[i][l]      = 1'b1;
        end
      end
      if (c.op == op_vmv_xs) begin
        a_l        = $signed(regs[c.vs2][sew-1:0]);  // Element 0 as a signed number
        exp_xrf[i] = a_l;
        xrf_q.push_back(i);
      end else begin
        regs[c.vd]  = new_v;
        exp_data[i] = new_v;
        rt_q.push_back(i);
        n_writes++;
      end
    end
  endtask

  task automatic check_vreg(input string what, input vdata_t exp_v, input vdata_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      $display("FAILED %s expected %h actual %h", what, exp_v, act_v);
      n_errors++;
    end
  endtask

  task automatic check_idx(input string what, input vreg_idx_t exp_v, input vreg_idx_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      $display("FAILED %s expected %0d actual %0d", what, exp_v, act_v);
      n_errors++;
    end
  endtask

  task automatic check_strb(input string what, input vstrb_t exp_v, input vstrb_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      $display("FAILED %s expected %b actual %b", what, exp_v, act_v);
      n_errors++;
    end
  endtask

  task automatic check_xrf(input string what, input xrf_data_t exp_v, input xrf_data_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      $display("FAILED %s expected %h actual %h", what, exp_v, act_v);
      n_errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp_v, input logic act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      $display("FAILED %s expected %b actual %b", what, exp_v, act_v);
      n_errors++;
    end
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    int k;
    if (rst_n) begin
      if (rt_valid) begin
        rt_count++;
        if (rt_q.size() == 0) begin
          $display("ERROR: retire report for v%0d arrived with none expected", rt_index);
          n_errors++;
        end else begin
          k = rt_q.pop_front();
          check_idx({case_name[k], " rt_index"}, case_tbl[k].inst.vd, rt_index);
          check_vreg({case_name[k], " rt_data"}, exp_data[k], rt_data);
          check_strb({case_name[k], " rt_strobe"}, exp_strb[k], rt_strobe);
          check_flag({case_name[k], " vxsat_set"}, exp_sat[k], vxsat_set);
        end
      end else if (vxsat_set) begin
        $display("ERROR: vxsat_set pulsed without a retire report");
        n_errors++;
      end
      if (xrf_valid && xrf_ready) begin
        if (xrf_q.size() == 0) begin
          $display("ERROR: scalar result %h returned with none expected", xrf_data);
          n_errors++;
        end else begin
          k = xrf_q.pop_front();
          check_xrf({case_name[k], " xrf_data"}, exp_xrf[k], xrf_data);
        end
      end
    end
  end

  // Scalar side back-pressure
  always @(posedge clk) begin
    #1;
    if (rst_n) xrf_ready = 1'($random(seed));
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("ERROR: the DUT hung, run stopped after %0d cycles", cycles);
      $display("Summary: %0d checks, %0d errors, %0d of %0d retire records",
               n_checks, n_errors, rt_count, n_writes);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    logic accepted;
    int   idle_sum;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    xrf_ready  = 1'b0;
    load_cases();
    predict();
    idle_sum = 0;
    foreach (case_tbl[i]) idle_sum += case_tbl[i].idle;
    cycle_limit = case_tbl.size() * 20 + idle_sum + 100;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_flag("reset inst_ready", 1'b1, inst_ready);
    check_flag("reset xrf_valid", 1'b0, xrf_valid);
    check_flag("reset rt_valid", 1'b0, rt_valid);
    @(posedge clk);
    #1;
    for (int i = 0; i < case_tbl.size(); i++) begin
      repeat (case_tbl[i].idle) begin
        @(posedge clk);
        #1;
      end
      inst_valid = 1'b1;
      inst       = case_tbl[i].inst;
      accepted   = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = inst_ready;  // Transfer at the coming edge
        @(posedge clk);
        #1;
      end
      inst_valid = 1'b0;
    end
    while (rt_q.size() != 0 || xrf_q.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);  // Catch stray reports
    if (rt_count != n_writes) begin
      $display("FAILED retire_count expected %0d actual %0d", n_writes, rt_count);
      n_errors++;
    end
    $display("Summary: %0d checks, %0d errors, %0d of %0d retire records",
             n_checks, n_errors, rt_count, n_writes);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/vec_backend.sv
`timescale 1ns/1ps
`default_nettype none

module vec_backend (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inst_valid,
  input  vec_pkg::vec_inst_t inst,
  output logic               inst_ready,
  output logic               xrf_valid,
  output vec_pkg::xrf_data_t xrf_data,
  input  logic               xrf_ready,
  output logic               rt_valid,
  output vec_pkg::vreg_idx_t rt_index,
  output vec_pkg::vdata_t    rt_data,
  output vec_pkg::vstrb_t    rt_strobe,
  output logic               vxsat_set
);

  import vec_pkg::*;

  logic      q_valid, q_ready;
  vec_inst_t q_inst;
  vreg_idx_t rd_idx_a, rd_idx_b;
  vdata_t    rd_data_a, rd_data_b;
  logic      d_valid, d_ready;
  vec_uop_t  d_uop;
  logic      e_valid, e_ready, e_sat, e_xs, e_writes;
  vreg_idx_t e_vd;
  vdata_t    e_result;
  vstrb_t    e_strb;
  logic      wr_en;
  vreg_idx_t wr_idx;
  vdata_t    wr_data;
  vstrb_t    wr_strb;
  logic      xq_valid, xq_ready;
  xrf_data_t xq_data;

  vec_fifo #(.payload_t(vec_inst_t), .depth(inst_q_depth)) u_inst_q (
    .clk(clk), .rst_n(rst_n),
    .in_valid(inst_valid), .in_data(inst), .in_ready(inst_ready),
    .out_valid(q_valid), .out_data(q_inst), .out_ready(q_ready)
  );

  uop_decode u_decode (
    .clk(clk), .rst_n(rst_n),
    .q_valid(q_valid), .q_inst(q_inst), .q_ready(q_ready),
    .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b), .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .d_valid(d_valid), .d_uop(d_uop), .d_ready(d_ready),
    .e_valid(e_valid), .e_vd(e_vd), .e_writes(e_writes)
  );

  vrf u_vrf (
    .clk(clk), .rst_n(rst_n),
    .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b), .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb)
  );

  vec_alu u_alu (
    .clk(clk), .rst_n(rst_n),
    .d_valid(d_valid), .d_uop(d_uop), .d_ready(d_ready),
    .e_valid(e_valid), .e_vd(e_vd), .e_result(e_result), .e_strb(e_strb),
    .e_sat(e_sat), .e_xs(e_xs), .e_writes(e_writes), .e_ready(e_ready)
  );

  retire_unit u_retire (
    .clk(clk), .rst_n(rst_n),
    .e_valid(e_valid), .e_vd(e_vd), .e_result(e_result), .e_strb(e_strb),
    .e_sat(e_sat), .e_xs(e_xs), .e_writes(e_writes), .e_ready(e_ready),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb),
    .rt_valid(rt_valid), .rt_index(rt_index), .rt_data(rt_data), .rt_strobe(rt_strobe),
    .vxsat_set(vxsat_set),
    .xq_valid(xq_valid), .xq_data(xq_data), .xq_ready(xq_ready)
  );

  vec_fifo #(.payload_t(xrf_data_t), .depth(xrf_q_depth)) u_xrf_q (
    .clk(clk), .rst_n(rst_n),
    .in_valid(xq_valid), .in_data(xq_data), .in_ready(xq_ready),
    .out_valid(xrf_valid), .out_data(xrf_data), .out_ready(xrf_ready)
  );

endmodule

`default_nettype wire

//--- logic/retire_unit.sv
`timescale 1ns/1ps
`default_nettype none

module retire_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                e_valid,
  input  vec_pkg::vreg_idx_t  e_vd,
  input  vec_pkg::vdata_t     e_result,
  input  vec_pkg::vstrb_t     e_strb,
  input  logic                e_sat,
  input  logic                e_xs,
  input  logic                e_writes,
  output logic                e_ready,
  output logic                wr_en,
  output vec_pkg::vreg_idx_t  wr_idx,
  output vec_pkg::vdata_t     wr_data,
  output vec_pkg::vstrb_t     wr_strb,
  output logic                rt_valid,
  output vec_pkg::vreg_idx_t  rt_index,
  output vec_pkg::vdata_t     rt_data,
  output vec_pkg::vstrb_t     rt_strobe,
  output logic                vxsat_set,
  output logic                xq_valid,
  output vec_pkg::xrf_data_t  xq_data,
  input  logic                xq_ready
);

  import vec_pkg::*;

  logic xq_take;

  // VRF write straight from the execute register
  assign wr_en   = e_valid && e_writes;
  assign wr_idx  = e_vd;
  assign wr_data = e_result;
  assign wr_strb = e_strb;

  // Only a scalar result can stall retire
  assign e_ready = !(e_valid && e_xs && xq_valid && !xq_ready);
  assign xq_take = e_valid && e_xs && e_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rt_valid  <= 1'b0;
      vxsat_set <= 1'b0;
      xq_valid  <= 1'b0;
    end else begin
      rt_valid  <= wr_en;
      vxsat_set <= wr_en && e_sat;
      if (xq_take)
        xq_valid <= 1'b1;
      else if (xq_ready)
        xq_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      rt_index  <= e_vd;
      rt_data   <= e_result;
      rt_strobe <= e_strb;
    end
    if (xq_take) xq_data <= {{(xlen-sew){e_result[sew-1]}}, e_result[sew-1:0]};  // Sign-extend
  end

endmodule

`default_nettype wire

//--- logic/vec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module vec_alu (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               d_valid,
  input  vec_pkg::vec_uop_t  d_uop,
  output logic               d_ready,
  output logic               e_valid,
  output vec_pkg::vreg_idx_t e_vd,
  output vec_pkg::vdata_t    e_result,
  output vec_pkg::vstrb_t    e_strb,
  output logic               e_sat,
  output logic               e_xs,
  output logic               e_writes,
  input  logic               e_ready
);

  import vec_pkg::*;

  vdata_t res;
  vstrb_t strb;
  vstrb_t clamp;

  always_comb begin
    logic signed [sew-1:0] a_l;
    logic signed [sew-1:0] b_l;
    logic        [sew:0]   sum;
    logic        [sew-1:0] lane;

    res   = d_uop.a;  // Tail lanes keep old vd
    strb  = '0;
    clamp = '0;
    for (int l = 0; l < num_lanes; l++) begin
      a_l     = d_uop.a[l*sew +: sew];
      b_l     = d_uop.b[l*sew +: sew];
      sum     = {a_l[sew-1], a_l} + {b_l[sew-1], b_l};
      strb[l] = (3'(l) < d_uop.vl);
      case (d_uop.op)
        op_vadd:   lane = sum[sew-1:0];
        op_vsub:   lane = a_l - b_l;     // vs2 - vs1, wraps
        op_vsadd: begin
          lane = sum[sew-1:0];
          if (sum[sew] != sum[sew-1]) begin  // Overflow, clamp
            lane     = sum[sew] ? {1'b1, {(sew-1){1'b0}}} : {1'b0, {(sew-1){1'b1}}};
            clamp[l] = 1'b1;
          end
        end
        op_vmv_vx: lane = b_l;
        default:   lane = a_l;
      endcase
      if (strb[l]) res[l*sew +: sew] = lane;
    end
  end

  assign d_ready = !e_valid || e_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      e_valid <= 1'b0;
    else if (d_ready)
      e_valid <= d_valid;
  end

  always_ff @(posedge clk) begin
    if (d_ready && d_valid) begin
      e_vd     <= d_uop.vd;
      e_result <= res;
      e_strb   <= strb;
      e_sat    <= |(clamp & strb);  // Only active lanes count
      e_xs     <= (d_uop.op == op_vmv_xs);
      e_writes <= (d_uop.op != op_vmv_xs);
    end
  end

endmodule

`default_nettype wire

//--- logic/uop_decode.sv
`timescale 1ns/1ps
`default_nettype none

module uop_decode (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               q_valid,
  input  vec_pkg::vec_inst_t q_inst,
  output logic               q_ready,
  output vec_pkg::vreg_idx_t rd_idx_a,
  output vec_pkg::vreg_idx_t rd_idx_b,
  input  vec_pkg::vdata_t    rd_data_a,
  input  vec_pkg::vdata_t    rd_data_b,
  output logic               d_valid,
  output vec_pkg::vec_uop_t  d_uop,
  input  logic               d_ready,
  input  logic               e_valid,
  input  vec_pkg::vreg_idx_t e_vd,
  input  logic               e_writes
);

  import vec_pkg::*;

  logic   vv_op;
  logic   writes;
  logic   need_tail;
  logic   tail_ok;
  logic   hazard;
  logic   fetch;
  logic   issue;
  vdata_t tail_buf;
  vdata_t a_val;
  vdata_t b_val;

  // Destination still in flight in decode or execute
  function automatic logic busy(vreg_idx_t idx);
    busy = (d_valid && d_uop.op != op_vmv_xs && d_uop.vd == idx) ||
           (e_valid && e_writes && e_vd == idx);
  endfunction

  assign vv_op  = q_inst.op inside {op_vadd, op_vsub, op_vsadd};
  assign writes = (q_inst.op != op_vmv_xs);
  // Tail lanes need old vd, which the two ports cannot supply alongside vs1 and vs2
  assign need_tail = vv_op && (q_inst.vl < num_lanes) && (q_inst.vd != q_inst.vs2);

  always_comb begin
    hazard = (vv_op && (busy(q_inst.vs1) || busy(q_inst.vs2))) ||
             (!writes && busy(q_inst.vs2)) ||
             (writes && busy(q_inst.vd));     // Old vd is a source too
  end

  assign fetch   = q_valid && !hazard && need_tail && !tail_ok;
  assign issue   = q_valid && !hazard && (!need_tail || tail_ok) && (!d_valid || d_ready);
  assign q_ready = issue;

  assign rd_idx_a = q_inst.vs1;
  assign rd_idx_b = (q_inst.op == op_vmv_vx || (need_tail && !tail_ok)) ? q_inst.vd
                                                                         : q_inst.vs2;

  always_comb begin
    a_val = rd_data_b;
    for (int l = 0; l < num_lanes; l++) begin
      if (tail_ok && 3'(l) >= q_inst.vl) a_val[l*sew +: sew] = tail_buf[l*sew +: sew];
    end
  end

  assign b_val = (q_inst.op == op_vmv_vx) ? {num_lanes{q_inst.rs1[sew-1:0]}} : rd_data_a;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail_ok <= 1'b0;
      d_valid <= 1'b0;
    end else begin
      if (fetch)
        tail_ok <= 1'b1;
      else if (issue)
        tail_ok <= 1'b0;
      if (!d_valid || d_ready) d_valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch) tail_buf <= rd_data_b;
    if (issue) begin
      d_uop.op     <= q_inst.op;
      d_uop.vd     <= q_inst.vd;
      d_uop.vl     <= q_inst.vl;
      d_uop.a      <= a_val;
      d_uop.b      <= b_val;
      d_uop.scalar <= q_inst.rs1;
    end
  end

endmodule

`default_nettype wire

//--- logic/vrf.sv
`timescale 1ns/1ps
`default_nettype none

module vrf (
  input  logic               clk,
  input  logic               rst_n,
  input  vec_pkg::vreg_idx_t rd_idx_a,
  input  vec_pkg::vreg_idx_t rd_idx_b,
  output vec_pkg::vdata_t    rd_data_a,
  output vec_pkg::vdata_t    rd_data_b,
  input  logic               wr_en,
  input  vec_pkg::vreg_idx_t wr_idx,
  input  vec_pkg::vdata_t    wr_data,
  input  vec_pkg::vstrb_t    wr_strb
);

  import vec_pkg::*;

  vdata_t regs [num_vregs];

  // Reads see the old value during the write cycle
  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < num_vregs; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_en) begin
      for (int l = 0; l < num_lanes; l++) begin
        if (wr_strb[l]) regs[wr_idx][l*sew +: sew] <= wr_data[l*sew +: sew];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/vec_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module vec_fifo #(
  parameter type payload_t = vec_pkg::vec_inst_t,
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  payload_t                     mem [depth];
  logic [$clog2(depth)-1:0]     wr_ptr;
  logic [$clog2(depth)-1:0]     rd_ptr;
  logic [$clog2(depth+1)-1:0]   count;
  logic                         push;
  logic                         pop;

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign in_ready  = (count != depth) || out_ready;  // Full but popping still takes a push
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Power-of-two depth wraps
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

endmodule

`default_nettype wire

//--- logic/vec_pkg.sv
`default_nettype none

package vec_pkg;

  localparam int vlen         = 64;
  localparam int sew          = 16;
  localparam int num_lanes    = vlen / sew;
  localparam int num_vregs    = 32;
  localparam int xlen         = 32;
  localparam int inst_q_depth = 4;
  localparam int xrf_q_depth  = 2;

  typedef logic [$clog2(num_vregs)-1:0] vreg_idx_t;
  typedef logic [vlen-1:0]              vdata_t;
  typedef logic [num_lanes-1:0]         vstrb_t;

  typedef enum logic [2:0] {
    op_vadd,
    op_vsub,
    op_vsadd,   // Signed saturating, sets vxsat
    op_vmv_vx,  // Scalar broadcast
    op_vmv_xs   // Element 0 back to scalar side
  } vec_op_e;

  // Instruction as sent by the scalar core
  typedef struct packed {
    vec_op_e          op;
    vreg_idx_t        vd;
    vreg_idx_t        vs1;
    vreg_idx_t        vs2;
    logic [2:0]       vl;   // 0 to num_lanes
    logic [xlen-1:0]  rs1;
  } vec_inst_t;

  // Operands already read from the VRF
  typedef struct packed {
    vec_op_e          op;
    vreg_idx_t        vd;
    logic [2:0]       vl;
    vdata_t           a;       // vs2, tail lanes hold old vd
    vdata_t           b;       // vs1 or broadcast scalar
    logic [xlen-1:0]  scalar;
  } vec_uop_t;

  // Scalar result returned by vmv.x.s
  typedef logic [xlen-1:0] xrf_data_t;

endpackage

`default_nettype wire
